// ==== source/usb_ohci_pkg.sv ====
// controller-wide types for the OHCI list service slice
// channel encoding, descriptor pointer and register map of the slave port
`default_nettype none

package usb_ohci_pkg;

  // descriptor pointer is a word address of 16-byte aligned descriptors
  localparam int PTR_W = 28;
  // byte address bits below the pointer
  localparam int PTR_LSB = 32 - PTR_W;

  // register slave address width in words
  localparam int WB_AW = 4;

  // zero pointer ends a list
  typedef logic [PTR_W-1:0] ed_ptr_t;

  // top bit set means non-periodic
  typedef enum logic [1:0] {
    ISOCHRONOUS = 2'd0,
    INTERRUPT   = 2'd1,
    CONTROL     = 2'd2,
    BULK        = 2'd3
  } channel_t;

  // register offsets in words
  localparam logic [WB_AW-1:0] REG_CONTROL      = 4'd0;
  localparam logic [WB_AW-1:0] REG_CONTROL_HEAD = 4'd1;
  localparam logic [WB_AW-1:0] REG_CONTROL_CUR  = 4'd2;
  localparam logic [WB_AW-1:0] REG_BULK_HEAD    = 4'd3;
  localparam logic [WB_AW-1:0] REG_BULK_CUR     = 4'd4;
  localparam logic [WB_AW-1:0] REG_PERIOD_CUR   = 4'd5;

  // control register: ratio in 1:0, start above it
  localparam int CTRL_START_BIT = 2;

  // current pointer update from the list service
  typedef struct packed {
    logic    en;
    ed_ptr_t val;
  } reg_wr_t;

endpackage

`default_nettype wire

// ==== source/usb_ohci_desc_pkg.sv ====
// descriptor word layouts and the decoded next-item record
// a fetched word is read as an ED or as a TD depending on its kind bit
`default_nettype none

package usb_ohci_desc_pkg;

  // kind bit values
  localparam logic KIND_ED = 1'b1;
  localparam logic KIND_TD = 1'b0;

  // endpoint descriptor view
  typedef struct packed {
    usb_ohci_pkg::ed_ptr_t  next;
    usb_ohci_pkg::channel_t ctype;
    logic                   halt;
    logic                   kind;
  } ed_word_t;

  // transfer descriptor view
  typedef struct packed {
    usb_ohci_pkg::ed_ptr_t next;
    logic [2:0]            cc;
    logic                  kind;
  } td_word_t;

  // same 32 bits, two readings
  typedef union packed {
    ed_word_t ed;
    td_word_t td;
  } desc_word_u;

  // decoded item handed to the list service
  typedef struct packed {
    logic                   valid;
    logic                   is_ed;
    logic                   halt;
    usb_ohci_pkg::channel_t ctype;
    usb_ohci_pkg::ed_ptr_t  addr;
  } next_item_t;

endpackage

`default_nettype wire

// ==== source/usb_ohci_list_regs.sv ====
// list pointer registers behind a Wishbone classic slave
// software sets heads, ratio and start; the list service updates the current pointers
`default_nettype none

module usb_ohci_list_regs (
  input  logic                             clk_i,
  input  logic                             arst_n_i,
  // Wishbone slave
  input  logic                             wb_cyc_i,
  input  logic                             wb_stb_i,
  input  logic                             wb_we_i,
  input  logic [usb_ohci_pkg::WB_AW-1:0]   wb_adr_i,
  input  logic [31:0]                      wb_dat_i,
  output logic [31:0]                      wb_dat_o,
  output logic                             wb_ack_o,
  // register values
  output logic                             start_o,
  output logic [1:0]                       ratio_o,
  output usb_ohci_pkg::ed_ptr_t            control_head_o,
  output usb_ohci_pkg::ed_ptr_t            bulk_head_o,
  output usb_ohci_pkg::ed_ptr_t            control_cur_o,
  output usb_ohci_pkg::ed_ptr_t            bulk_cur_o,
  output usb_ohci_pkg::ed_ptr_t            period_cur_o,
  // updates from the list service
  input  usb_ohci_pkg::reg_wr_t            control_cur_wr_i,
  input  usb_ohci_pkg::reg_wr_t            bulk_cur_wr_i,
  input  usb_ohci_pkg::reg_wr_t            period_cur_wr_i
);
  import usb_ohci_pkg::*;

  logic    ack_q;
  logic    start_q;
  logic [1:0] ratio_q;
  ed_ptr_t control_head_q;
  ed_ptr_t bulk_head_q;
  ed_ptr_t control_cur_q;
  ed_ptr_t bulk_cur_q;
  ed_ptr_t period_cur_q;
  logic    bus_wr;
  ed_ptr_t wr_ptr;

  // write lands on the ack cycle
  assign bus_wr = wb_cyc_i & wb_stb_i & ack_q & wb_we_i;
  // pointers live in the upper bits of the byte address
  assign wr_ptr = wb_dat_i[31:PTR_LSB];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q          <= 1'b0;
      start_q        <= 1'b0;
      ratio_q        <= 2'd0;
      control_head_q <= '0;
      bulk_head_q    <= '0;
      control_cur_q  <= '0;
      bulk_cur_q     <= '0;
      period_cur_q   <= '0;
    end else begin
      // one cycle ack, low again while stb still high
      ack_q <= wb_cyc_i & wb_stb_i & ~ack_q;
      if (bus_wr && wb_adr_i == REG_CONTROL) begin
        start_q <= wb_dat_i[CTRL_START_BIT];
        ratio_q <= wb_dat_i[1:0];
      end
      if (bus_wr && wb_adr_i == REG_CONTROL_HEAD) begin
        control_head_q <= wr_ptr;
      end
      if (bus_wr && wb_adr_i == REG_BULK_HEAD) begin
        bulk_head_q <= wr_ptr;
      end
      // list service has priority over the bus
      if (control_cur_wr_i.en) begin
        control_cur_q <= control_cur_wr_i.val;
      end else if (bus_wr && wb_adr_i == REG_CONTROL_CUR) begin
        control_cur_q <= wr_ptr;
      end
      if (bulk_cur_wr_i.en) begin
        bulk_cur_q <= bulk_cur_wr_i.val;
      end else if (bus_wr && wb_adr_i == REG_BULK_CUR) begin
        bulk_cur_q <= wr_ptr;
      end
      if (period_cur_wr_i.en) begin
        period_cur_q <= period_cur_wr_i.val;
      end else if (bus_wr && wb_adr_i == REG_PERIOD_CUR) begin
        period_cur_q <= wr_ptr;
      end
    end
  end

  // read mux, sampled by the host on ack
  always_comb begin
    wb_dat_o = '0;
    case (wb_adr_i)
      REG_CONTROL: begin
        wb_dat_o[1:0]            = ratio_q;
        wb_dat_o[CTRL_START_BIT] = start_q;
      end
      REG_CONTROL_HEAD: wb_dat_o = {control_head_q, {PTR_LSB{1'b0}}};
      REG_CONTROL_CUR:  wb_dat_o = {control_cur_q, {PTR_LSB{1'b0}}};
      REG_BULK_HEAD:    wb_dat_o = {bulk_head_q, {PTR_LSB{1'b0}}};
      REG_BULK_CUR:     wb_dat_o = {bulk_cur_q, {PTR_LSB{1'b0}}};
      REG_PERIOD_CUR:   wb_dat_o = {period_cur_q, {PTR_LSB{1'b0}}};
      default:          wb_dat_o = '0;
    endcase
  end

  assign wb_ack_o       = ack_q;
  assign start_o        = start_q;
  assign ratio_o        = ratio_q;
  assign control_head_o = control_head_q;
  assign bulk_head_o    = bulk_head_q;
  assign control_cur_o  = control_cur_q;
  assign bulk_cur_o     = bulk_cur_q;
  assign period_cur_o   = period_cur_q;

  // host must keep cyc up until the ack has gone by
  assert property (@(posedge clk_i) disable iff (!arst_n_i) wb_ack_o |-> wb_cyc_i);

endmodule

`default_nettype wire

// ==== source/usb_ohci_desc_decode.sv ====
// decode stage of the descriptor loop
// registers a fetched word and splits it into pointer, kind and channel type
`default_nettype none

module usb_ohci_desc_decode (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  input  logic                         word_valid_i,
  input  usb_ohci_desc_pkg::desc_word_u word_i,
  input  usb_ohci_pkg::channel_t       word_type_i,
  output usb_ohci_desc_pkg::next_item_t next_o
);
  import usb_ohci_pkg::*;
  import usb_ohci_desc_pkg::*;

  logic       valid_q;
  desc_word_u word_q;
  // tag of the ED that owns a TD
  channel_t   tag_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      // one cycle pulse per fetched word
      valid_q <= word_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (word_valid_i) begin
      word_q <= word_i;
      tag_q  <= word_type_i;
    end
  end

  always_comb begin
    next_o.valid = valid_q;
    if (word_q.ed.kind == KIND_ED) begin
      // ED view carries its own channel type
      next_o.is_ed = 1'b1;
      next_o.halt  = word_q.ed.halt;
      next_o.ctype = word_q.ed.ctype;
      next_o.addr  = word_q.ed.next;
    end else begin
      // TD view inherits the type from the request tag
      next_o.is_ed = 1'b0;
      next_o.halt  = 1'b0;
      next_o.ctype = tag_q;
      next_o.addr  = word_q.td.next;
    end
  end

endmodule

`default_nettype wire

// ==== source/usb_ohci_listservice.sv ====
// execute stage: schedules the four channel types and picks the next descriptor
// one decoded item comes in, one fetch request goes out in the same cycle
`default_nettype none

module usb_ohci_listservice (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic                          start_i,
  // high while the frame is in the periodic zone
  input  logic                          frame_periodic_i,
  input  logic [1:0]                    ratio_i,
  input  usb_ohci_pkg::ed_ptr_t         control_head_i,
  input  usb_ohci_pkg::ed_ptr_t         bulk_head_i,
  input  usb_ohci_pkg::ed_ptr_t         control_cur_i,
  input  usb_ohci_pkg::ed_ptr_t         bulk_cur_i,
  input  usb_ohci_pkg::ed_ptr_t         period_cur_i,
  input  usb_ohci_desc_pkg::next_item_t next_i,
  input  logic                          fetch_ready_i,
  output logic                          next_ready_o,
  output usb_ohci_pkg::reg_wr_t         control_cur_wr_o,
  output usb_ohci_pkg::reg_wr_t         bulk_cur_wr_o,
  output usb_ohci_pkg::reg_wr_t         period_cur_wr_o,
  output logic                          req_valid_o,
  output usb_ohci_pkg::ed_ptr_t         req_addr_o,
  output usb_ohci_pkg::channel_t        req_type_o
);
  import usb_ohci_pkg::*;

  logic       run_q;
  logic       kick_q;
  logic       wait_q;
  logic       next_ready_q;
  logic       bulk_turn_q;
  logic [1:0] ctrl_cnt_q;

  logic       ed_seen;
  logic       ed_live;
  logic       ctrl_served;
  logic       bulk_served;
  logic       ratio_hit;
  logic       zone_change;
  logic       chan_change;
  logic       bulk_next;
  logic       resume;
  logic       sel_valid;
  ed_ptr_t    sel_addr;
  channel_t   sel_type;
  logic       ptr_zero;
  logic       head_use;
  logic       go_wait;

  // halted EDs are followed but never counted
  assign ed_seen     = next_i.valid & next_i.is_ed;
  assign ed_live     = ed_seen & ~next_i.halt;
  assign ctrl_served = ed_live & (next_i.ctype == CONTROL);
  assign bulk_served = ed_live & (next_i.ctype == BULK);
  // ratio+1 control EDs done
  assign ratio_hit   = ctrl_served & (ctrl_cnt_q == ratio_i);
  // periodic ED in a non-periodic frame or the other way round
  assign zone_change = (next_i.ctype[1] == frame_periodic_i);
  // one bulk ED then back to control
  assign chan_change = ed_live & (zone_change | ratio_hit | bulk_served);
  assign bulk_next   = ctrl_served ? ratio_hit : (bulk_served ? 1'b0 : bulk_turn_q);
  // periodic list ran dry, go on once the frame leaves the periodic zone
  assign resume      = wait_q & ~frame_periodic_i & fetch_ready_i;

  // candidate address before the end-of-list check
  always_comb begin
    sel_valid = 1'b0;
    sel_addr  = '0;
    sel_type  = CONTROL;
    if (kick_q) begin
      // zero pointer forces the control head
      sel_valid = 1'b1;
    end else if (resume) begin
      sel_valid = 1'b1;
      sel_addr  = bulk_turn_q ? bulk_cur_i : control_cur_i;
      sel_type  = bulk_turn_q ? BULK : CONTROL;
    end else if (next_i.valid) begin
      sel_valid = 1'b1;
      if (chan_change) begin
        if (frame_periodic_i) begin
          sel_addr = period_cur_i;
          sel_type = INTERRUPT;
        end else if (bulk_next) begin
          sel_addr = bulk_cur_i;
          sel_type = BULK;
        end else begin
          sel_addr = control_cur_i;
          sel_type = CONTROL;
        end
      end else begin
        // TD chain or same channel, follow the pointer
        sel_addr = next_i.addr;
        sel_type = next_i.ctype;
      end
    end
  end

  // end of list: heads for control and bulk, idle for periodic
  assign ptr_zero = (sel_addr == '0);
  assign head_use = sel_valid & ptr_zero & sel_type[1];
  assign go_wait  = sel_valid & ptr_zero & ~sel_type[1];

  assign req_valid_o = sel_valid & ~go_wait;
  assign req_type_o  = sel_type;
  always_comb begin
    req_addr_o = sel_addr;
    if (head_use) begin
      req_addr_o = (sel_type == BULK) ? bulk_head_i : control_head_i;
    end
  end

  // current registers hold the resume point of each list
  always_comb begin
    control_cur_wr_o.en  = (ed_seen & (next_i.ctype == CONTROL)) |
                           (head_use & (sel_type == CONTROL));
    control_cur_wr_o.val = (head_use & (sel_type == CONTROL)) ? control_head_i : next_i.addr;
    bulk_cur_wr_o.en     = (ed_seen & (next_i.ctype == BULK)) |
                           (head_use & (sel_type == BULK));
    bulk_cur_wr_o.val    = (head_use & (sel_type == BULK)) ? bulk_head_i : next_i.addr;
    period_cur_wr_o.en   = ed_seen & ~next_i.ctype[1];
    period_cur_wr_o.val  = next_i.addr;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      run_q        <= 1'b0;
      kick_q       <= 1'b0;
      wait_q       <= 1'b0;
      next_ready_q <= 1'b0;
      bulk_turn_q  <= 1'b0;
      ctrl_cnt_q   <= 2'd0;
    end else begin
      // first head goes out one cycle after start
      run_q        <= run_q | start_i;
      kick_q       <= start_i & ~run_q;
      next_ready_q <= run_q & ~wait_q;
      if (go_wait) begin
        wait_q <= 1'b1;
      end else if (resume) begin
        wait_q <= 1'b0;
      end
      if (ctrl_served) begin
        ctrl_cnt_q  <= ratio_hit ? 2'd0 : ctrl_cnt_q + 2'd1;
        bulk_turn_q <= ratio_hit;
      end else if (bulk_served) begin
        bulk_turn_q <= 1'b0;
      end
    end
  end

  assign next_ready_o = next_ready_q;

  // only one descriptor in flight around the loop
  assert property (@(posedge clk_i) disable iff (!arst_n_i) next_i.valid |-> next_ready_o);
  assert property (@(posedge clk_i) disable iff (!arst_n_i) req_valid_o |=> !req_valid_o);

endmodule

`default_nettype wire

// ==== source/usb_ohci_desc_fetch.sv ====
// result stage: Wishbone classic read master for one descriptor word per request
// word and channel tag come back on the ack cycle
`default_nettype none

module usb_ohci_desc_fetch (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  // request from the list service
  input  logic                          req_valid_i,
  input  usb_ohci_pkg::ed_ptr_t         req_addr_i,
  input  usb_ohci_pkg::channel_t        req_type_i,
  output logic                          req_ready_o,
  // Wishbone master, read only
  output logic                          wbm_cyc_o,
  output logic                          wbm_stb_o,
  output logic [31:0]                   wbm_adr_o,
  input  logic [31:0]                   wbm_dat_i,
  input  logic                          wbm_ack_i,
  // fetched word to decode
  output logic                          word_valid_o,
  output usb_ohci_desc_pkg::desc_word_u word_o,
  output usb_ohci_pkg::channel_t        word_type_o
);
  import usb_ohci_pkg::*;

  logic        cyc_q;
  logic [31:0] adr_q;
  channel_t    type_q;
  logic        take;

  // idle master accepts a request
  assign take = req_valid_i & ~cyc_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cyc_q <= 1'b0;
    end else if (cyc_q) begin
      // hold the cycle until memory answers
      if (wbm_ack_i) begin
        cyc_q <= 1'b0;
      end
    end else if (take) begin
      cyc_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      // pointer to byte address
      adr_q  <= {req_addr_i, {PTR_LSB{1'b0}}};
      type_q <= req_type_i;
    end
  end

  assign req_ready_o = ~cyc_q;
  assign wbm_cyc_o   = cyc_q;
  assign wbm_stb_o   = cyc_q;
  assign wbm_adr_o   = adr_q;

  // decode captures the data on the ack cycle
  assign word_valid_o = cyc_q & wbm_ack_i;
  assign word_o       = wbm_dat_i;
  assign word_type_o  = type_q;

  // one descriptor in flight so a request never meets a busy master
  assert property (@(posedge clk_i) disable iff (!arst_n_i) req_valid_i |-> req_ready_o);

endmodule

`default_nettype wire

// ==== source/usb_ohci_list_top.sv ====
// list service slice: registers, list service, descriptor fetch and decode
// register slave for software, descriptor master toward system memory
`default_nettype none

module usb_ohci_list_top (
  input  logic                           clk_i,
  input  logic                           arst_n_i,
  input  logic                           frame_periodic_i,
  // register slave
  input  logic                           wbs_cyc_i,
  input  logic                           wbs_stb_i,
  input  logic                           wbs_we_i,
  input  logic [usb_ohci_pkg::WB_AW-1:0] wbs_adr_i,
  input  logic [31:0]                    wbs_dat_i,
  output logic [31:0]                    wbs_dat_o,
  output logic                           wbs_ack_o,
  // descriptor master
  output logic                           wbm_cyc_o,
  output logic                           wbm_stb_o,
  output logic [31:0]                    wbm_adr_o,
  input  logic [31:0]                    wbm_dat_i,
  input  logic                           wbm_ack_i
);
  import usb_ohci_pkg::*;
  import usb_ohci_desc_pkg::*;

  logic       start;
  logic [1:0] ratio;
  ed_ptr_t    control_head;
  ed_ptr_t    bulk_head;
  ed_ptr_t    control_cur;
  ed_ptr_t    bulk_cur;
  ed_ptr_t    period_cur;
  reg_wr_t    control_cur_wr;
  reg_wr_t    bulk_cur_wr;
  reg_wr_t    period_cur_wr;
  logic       req_valid;
  logic       req_ready;
  ed_ptr_t    req_addr;
  channel_t   req_type;
  logic       word_valid;
  desc_word_u word;
  channel_t   word_type;
  next_item_t next_item;
  logic       next_ready;

  usb_ohci_list_regs i_regs (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .wb_cyc_i         (wbs_cyc_i),
    .wb_stb_i         (wbs_stb_i),
    .wb_we_i          (wbs_we_i),
    .wb_adr_i         (wbs_adr_i),
    .wb_dat_i         (wbs_dat_i),
    .wb_dat_o         (wbs_dat_o),
    .wb_ack_o         (wbs_ack_o),
    .start_o          (start),
    .ratio_o          (ratio),
    .control_head_o   (control_head),
    .bulk_head_o      (bulk_head),
    .control_cur_o    (control_cur),
    .bulk_cur_o       (bulk_cur),
    .period_cur_o     (period_cur),
    .control_cur_wr_i (control_cur_wr),
    .bulk_cur_wr_i    (bulk_cur_wr),
    .period_cur_wr_i  (period_cur_wr)
  );

  usb_ohci_listservice i_listservice (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .start_i          (start),
    .frame_periodic_i (frame_periodic_i),
    .ratio_i          (ratio),
    .control_head_i   (control_head),
    .bulk_head_i      (bulk_head),
    .control_cur_i    (control_cur),
    .bulk_cur_i       (bulk_cur),
    .period_cur_i     (period_cur),
    .next_i           (next_item),
    .fetch_ready_i    (req_ready),
    .next_ready_o     (next_ready),
    .control_cur_wr_o (control_cur_wr),
    .bulk_cur_wr_o    (bulk_cur_wr),
    .period_cur_wr_o  (period_cur_wr),
    .req_valid_o      (req_valid),
    .req_addr_o       (req_addr),
    .req_type_o       (req_type)
  );

  usb_ohci_desc_fetch i_fetch (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .req_valid_i  (req_valid),
    .req_addr_i   (req_addr),
    .req_type_i   (req_type),
    .req_ready_o  (req_ready),
    .wbm_cyc_o    (wbm_cyc_o),
    .wbm_stb_o    (wbm_stb_o),
    .wbm_adr_o    (wbm_adr_o),
    .wbm_dat_i    (wbm_dat_i),
    .wbm_ack_i    (wbm_ack_i),
    .word_valid_o (word_valid),
    .word_o       (word),
    .word_type_o  (word_type)
  );

  usb_ohci_desc_decode i_decode (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .word_valid_i (word_valid),
    .word_i       (word),
    .word_type_i  (word_type),
    .next_o       (next_item)
  );

endmodule

`default_nettype wire

// ==== verification/usb_ohci_list_tb.sv ====
// testbench for the OHCI list service slice
// random descriptor lists, a bus memory model and a scheduling model predict every fetch
`default_nettype none

module usb_ohci_list_tb;
  import usb_ohci_pkg::*;

  localparam int N_PHASE     = 4;
  localparam int N_FETCH     = 60;
  // 40 cycles per predicted fetch plus setup slack
  localparam int CYCLE_LIMIT = 40 * N_PHASE * N_FETCH + 200;

  logic             clk = 1'b0;
  logic             arst_n;
  logic             frame_periodic;
  logic             wbs_cyc;
  logic             wbs_stb;
  logic             wbs_we;
  logic [WB_AW-1:0] wbs_adr;
  logic [31:0]      wbs_dat_w;
  logic [31:0]      wbs_dat_r;
  logic             wbs_ack;
  logic             wbm_cyc;
  logic             wbm_stb;
  logic [31:0]      wbm_adr;
  logic [31:0]      wbm_dat;
  logic             wbm_ack;

  // descriptor memory indexed by pointer
  logic [31:0] mem [0:255];
  ed_ptr_t     free_ptrs [$];

  // list model state
  ed_ptr_t     mdl_control_head;
  ed_ptr_t     mdl_bulk_head;
  ed_ptr_t     mdl_control_cur;
  ed_ptr_t     mdl_bulk_cur;
  ed_ptr_t     mdl_period_cur;
  ed_ptr_t     mdl_addr;
  channel_t    mdl_tag;
  logic [1:0]  mdl_ratio;
  logic [1:0]  mdl_cnt;
  logic        mdl_bulk_turn;
  logic        mdl_waiting;
  logic        frame_q;
  int          live_ctrl_run;
  int          cycle_cnt;

  always #4 clk = ~clk;

  usb_ohci_list_top uut (
    .clk_i            (clk),
    .arst_n_i         (arst_n),
    .frame_periodic_i (frame_periodic),
    .wbs_cyc_i        (wbs_cyc),
    .wbs_stb_i        (wbs_stb),
    .wbs_we_i         (wbs_we),
    .wbs_adr_i        (wbs_adr),
    .wbs_dat_i        (wbs_dat_w),
    .wbs_dat_o        (wbs_dat_r),
    .wbs_ack_o        (wbs_ack),
    .wbm_cyc_o        (wbm_cyc),
    .wbm_stb_o        (wbm_stb),
    .wbm_adr_o        (wbm_adr),
    .wbm_dat_i        (wbm_dat),
    .wbm_ack_i        (wbm_ack)
  );

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    if (exp !== act) begin
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
      $display("Something failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // one classic cycle on the register slave
  task automatic reg_access(input logic we, input logic [WB_AW-1:0] adr,
                            input logic [31:0] wdat, output logic [31:0] rdat);
    @(posedge clk);
    wbs_cyc   <= 1'b1;
    wbs_stb   <= 1'b1;
    wbs_we    <= we;
    wbs_adr   <= adr;
    wbs_dat_w <= wdat;
    do @(negedge clk); while (!wbs_ack);
    rdat = wbs_dat_r;
    @(posedge clk);
    wbs_cyc <= 1'b0;
    wbs_stb <= 1'b0;
    wbs_we  <= 1'b0;
    // ack must be gone one cycle later
    @(negedge clk);
    check_value("register ack width", 32'd0, {31'd0, wbs_ack});
  endtask

  // one list of 1 to 6 EDs with up to two TDs after each
  task automatic build_list(input channel_t list_type, output ed_ptr_t head);
    ed_ptr_t    addr_q [$];
    logic [3:0] low_q [$];
    ed_ptr_t    nxt;
    ed_ptr_t    cur;
    int         n_ed;
    int         n_td;
    int         e;
    int         t;
    int         i;
    logic [1:0] ctype;
    logic       halt;
    n_ed = 1 + $urandom % 6;
    for (e = 0; e < n_ed; e++) begin
      // periodic lists mix isochronous and interrupt EDs
      ctype = list_type[1] ? list_type : 2'($urandom % 2);
      // head ED stays live so the list always makes progress
      halt = (e != 0) && ($urandom % 4 == 0);
      addr_q.push_back(free_ptrs.pop_front());
      low_q.push_back({ctype, halt, 1'b1});
      n_td = $urandom % 3;
      for (t = 0; t < n_td; t++) begin
        addr_q.push_back(free_ptrs.pop_front());
        low_q.push_back({3'($urandom), 1'b0});
      end
    end
    // chained in order with a zero pointer at the end
    for (i = 0; i < addr_q.size(); i++) begin
      cur = addr_q[i];
      nxt = (i + 1 < addr_q.size()) ? addr_q[i + 1] : ed_ptr_t'(0);
      mem[cur[7:0]] = {nxt, low_q[i]};
    end
    head = addr_q[0];
  endtask

  task automatic build_lists(output ed_ptr_t c_head, output ed_ptr_t b_head,
                             output ed_ptr_t p_head);
    int      i;
    int      j;
    ed_ptr_t tmp;
    // unused words carry their own address
    for (i = 0; i < 256; i++) begin
      mem[i] = {~i[7:0], i[7:0], i[7:0] ^ 8'ha5, 8'h3c};
    end
    // shuffled pool of nonzero pointers
    free_ptrs.delete();
    for (i = 1; i < 256; i++) begin
      free_ptrs.push_back(ed_ptr_t'(i));
    end
    for (i = 254; i > 0; i--) begin
      j            = $urandom % (i + 1);
      tmp          = free_ptrs[i];
      free_ptrs[i] = free_ptrs[j];
      free_ptrs[j] = tmp;
    end
    build_list(CONTROL, c_head);
    build_list(BULK, b_head);
    build_list(INTERRUPT, p_head);
  endtask

  // zero pointer reuses the control or bulk head and idles on periodic
  task automatic choose_pointer(input ed_ptr_t ptr, input channel_t ctype);
    mdl_waiting = 1'b0;
    mdl_tag     = ctype;
    mdl_addr    = ptr;
    if (ptr == '0) begin
      if (ctype == CONTROL) begin
        mdl_addr        = mdl_control_head;
        mdl_control_cur = mdl_control_head;
      end else if (ctype == BULK) begin
        mdl_addr     = mdl_bulk_head;
        mdl_bulk_cur = mdl_bulk_head;
      end else begin
        mdl_waiting = 1'b1;
      end
    end
  endtask

  // after a dry periodic list go back to the non-periodic list whose turn it is
  task automatic resume_after_wait();
    if (mdl_bulk_turn) begin
      choose_pointer(mdl_bulk_cur, BULK);
    end else begin
      choose_pointer(mdl_control_cur, CONTROL);
    end
  endtask

  task automatic predict_item(input logic [31:0] w, input logic frame);
    logic     is_ed;
    logic     live;
    logic     ctrl;
    logic     blk;
    logic     hit;
    logic     zone_mismatch;
    logic     to_bulk;
    channel_t ctype;
    channel_t sel_type;
    ed_ptr_t  nxt;
    ed_ptr_t  sel_ptr;
    is_ed = w[0];
    ctype = is_ed ? channel_t'(w[3:2]) : mdl_tag;
    nxt   = w[31:4];
    live  = is_ed && !w[1];
    ctrl  = live && (ctype == CONTROL);
    blk   = live && (ctype == BULK);
    hit   = ctrl && (mdl_cnt == mdl_ratio);
    // periodic type against the frame zone
    zone_mismatch = ((ctype == ISOCHRONOUS) || (ctype == INTERRUPT)) != frame;
    to_bulk = ctrl ? hit : (blk ? 1'b0 : mdl_bulk_turn);
    if (live && (zone_mismatch || hit || blk)) begin
      if (frame) begin
        sel_ptr  = mdl_period_cur;
        sel_type = INTERRUPT;
      end else if (to_bulk) begin
        sel_ptr  = mdl_bulk_cur;
        sel_type = BULK;
      end else begin
        sel_ptr  = mdl_control_cur;
        sel_type = CONTROL;
      end
    end else begin
      sel_ptr  = nxt;
      sel_type = ctype;
    end
    // each ED moves the current pointer of its own type even when halted
    if (is_ed) begin
      if (ctype == CONTROL) begin
        mdl_control_cur = nxt;
      end else if (ctype == BULK) begin
        mdl_bulk_cur = nxt;
      end else begin
        mdl_period_cur = nxt;
      end
    end
    if (ctrl) begin
      mdl_cnt       = hit ? 2'd0 : mdl_cnt + 2'd1;
      mdl_bulk_turn = hit;
    end else if (blk) begin
      mdl_bulk_turn = 1'b0;
    end
    choose_pointer(sel_ptr, sel_type);
  endtask

  task automatic wait_request();
    do @(negedge clk); while (!(wbm_cyc && wbm_stb));
  endtask

  // memory answers after 0 to 3 wait cycles and the frame zone moves with the ack
  task automatic answer_fetch();
    logic [31:0] word;
    logic        new_frame;
    word      = mem[wbm_adr[11:4]];
    new_frame = ($urandom % 3 == 0);
    repeat ($urandom % 4) @(posedge clk);
    @(posedge clk);
    wbm_ack        <= 1'b1;
    wbm_dat        <= word;
    frame_periodic <= new_frame;
    frame_q = new_frame;
    @(posedge clk);
    wbm_ack <= 1'b0;
    // master lets go of the bus right after the ack
    @(negedge clk);
    check_value("fetch bus released", 32'd0, {30'd0, wbm_cyc, wbm_stb});
    // live control EDs between two live bulk EDs
    if (word[0] && !word[1] && word[3:2] == CONTROL) begin
      live_ctrl_run++;
    end
    if (word[0] && !word[1] && word[3:2] == BULK) begin
      check_value("control EDs before bulk", int'(mdl_ratio) + 1, live_ctrl_run);
      live_ctrl_run = 0;
    end
    predict_item(word, new_frame);
  endtask

  task automatic run_phase(input logic [1:0] ratio);
    ed_ptr_t     c_head;
    ed_ptr_t     b_head;
    ed_ptr_t     p_head;
    logic [31:0] rdat;
    int          k;
    @(posedge clk);
    arst_n         <= 1'b0;
    frame_periodic <= 1'b0;
    wbm_ack        <= 1'b0;
    frame_q = 1'b0;
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;
    build_lists(c_head, b_head, p_head);
    reg_access(1'b1, REG_CONTROL_HEAD, {c_head, 4'h0}, rdat);
    reg_access(1'b1, REG_BULK_HEAD, {b_head, 4'h0}, rdat);
    reg_access(1'b1, REG_PERIOD_CUR, {p_head, 4'h0}, rdat);
    reg_access(1'b1, REG_CONTROL, {30'd0, ratio}, rdat);
    reg_access(1'b0, REG_CONTROL_HEAD, 32'd0, rdat);
    check_value("control head readback", {c_head, 4'h0}, rdat);
    reg_access(1'b0, REG_BULK_HEAD, 32'd0, rdat);
    check_value("bulk head readback", {b_head, 4'h0}, rdat);
    reg_access(1'b0, REG_PERIOD_CUR, 32'd0, rdat);
    check_value("period current readback", {p_head, 4'h0}, rdat);
    reg_access(1'b0, REG_CONTROL, 32'd0, rdat);
    check_value("ratio readback", {30'd0, ratio}, rdat);
    // model starts from the reset state of the list service
    mdl_control_head = c_head;
    mdl_bulk_head    = b_head;
    mdl_control_cur  = '0;
    mdl_bulk_cur     = '0;
    mdl_period_cur   = p_head;
    mdl_ratio        = ratio;
    mdl_cnt          = 2'd0;
    mdl_bulk_turn    = 1'b0;
    live_ctrl_run    = 0;
    reg_access(1'b1, REG_CONTROL, (32'd1 << CTRL_START_BIT) | ratio, rdat);
    reg_access(1'b0, REG_CONTROL, 32'd0, rdat);
    check_value("start readback", (32'd1 << CTRL_START_BIT) | ratio, rdat);
    // first fetch is the control head
    choose_pointer('0, CONTROL);
    for (k = 0; k < N_FETCH; k++) begin
      if (mdl_waiting) begin
        // let the frame leave the periodic zone
        if (frame_q) begin
          repeat (1 + $urandom % 4) @(posedge clk);
          frame_periodic <= 1'b0;
          frame_q = 1'b0;
        end
        resume_after_wait();
      end
      wait_request();
      check_value($sformatf("fetch %0d address", k), {mdl_addr, 4'h0}, wbm_adr);
      // last request stays pending so the registers hold still
      if (k < N_FETCH - 1) begin
        answer_fetch();
      end
    end
    reg_access(1'b0, REG_CONTROL_CUR, 32'd0, rdat);
    check_value("control current readback", {mdl_control_cur, 4'h0}, rdat);
    reg_access(1'b0, REG_BULK_CUR, 32'd0, rdat);
    check_value("bulk current readback", {mdl_bulk_cur, 4'h0}, rdat);
    reg_access(1'b0, REG_PERIOD_CUR, 32'd0, rdat);
    check_value("period current end", {mdl_period_cur, 4'h0}, rdat);
  endtask

  initial begin
    int r;
    arst_n         = 1'b0;
    frame_periodic = 1'b0;
    wbs_cyc        = 1'b0;
    wbs_stb        = 1'b0;
    wbs_we         = 1'b0;
    wbs_adr        = '0;
    wbs_dat_w      = 32'd0;
    wbm_dat        = 32'd0;
    wbm_ack        = 1'b0;
    void'($urandom(32'hf6f1));
    // one phase per ratio value
    for (r = 0; r < N_PHASE; r++) begin
      run_phase(2'(r));
    end
    $display("Everything OK");
    $finish;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: the descriptor loop stopped making progress");
    $display("Something failed");
    $fatal(1, "cycle limit reached");
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
source/usb_ohci_pkg.sv
source/usb_ohci_desc_pkg.sv
source/usb_ohci_list_regs.sv
source/usb_ohci_desc_decode.sv
source/usb_ohci_listservice.sv
source/usb_ohci_desc_fetch.sv
source/usb_ohci_list_top.sv
verification/usb_ohci_list_tb.sv
